// File: vlog.f
+incdir+include
src/bp_fetch_pkg.sv
src/bp_commit_pkg.sv
src/target_predictor.sv
src/return_stack.sv
src/next_pc_select.sv
src/branch_predictor.sv
verif/tb_branch_predictor.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_branch_predictor
RTL_TOP   ?= branch_predictor
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ns
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall

RTL_SRCS = src/bp_fetch_pkg.sv src/bp_commit_pkg.sv src/target_predictor.sv \
           src/return_stack.sv src/next_pc_select.sv src/branch_predictor.sv
SRCS     = $(RTL_SRCS) verif/tb_branch_predictor.sv include/bp_cfg.svh

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --timescale $(TIMESCALE) +incdir+include \
		--top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)

// File: verif/tb_branch_predictor.sv
`timescale 1ns/1ns
`include "bp_cfg.svh"

module tb_branch_predictor;

  localparam int RAND_CYCLES     = 80;
  // reset, up to fifty directed transactions of four cycles, then the random phase.
  localparam int WATCHDOG_CYCLES = 10 + 50 * 4 + 2 * RAND_CYCLES + 30;

  typedef struct packed {
    logic                            valid;
    logic [bp_fetch_pkg::SLOT_W-1:0] slot;
    logic [`BP_PLEN-1:0]             slot_pc;
    logic [`BP_PLEN-1:0]             npc;
    logic                            is_call;
    logic                            is_ret;
  } expect_t;

  logic                          clk_i;
  logic                          rst_i;
  logic                          req_valid_i;
  bp_fetch_pkg::fetch_req_t      req_i;
  logic                          req_ready_o;
  logic                          pred_valid_o;
  bp_fetch_pkg::prediction_t     pred_o;
  logic                          credit_return_i;
  logic                          upd_valid_i;
  bp_commit_pkg::branch_update_t upd_i;
  logic                          flush_i;

  string   test_name;
  logic    auto_credit;
  expect_t exp_now;
  expect_t exp_q;
  logic    acc_q;
  logic    accept_m;
  int      model_credits;
  integer  seed = 32'h2f9c3e9a;

  bp_commit_pkg::branch_kind_e kind_at [logic [`BP_PLEN-1:0]];   // committed kind per pc.

  branch_predictor dut_i (.*);

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference: credit count and expected prediction per accepted fetch
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign accept_m = req_valid_i && (model_credits != 0);

  always @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      model_credits <= `BP_CREDITS;
      acc_q         <= 1'b0;
      exp_q         <= '0;
    end else begin
      model_credits <= model_credits - int'(accept_m) + int'(credit_return_i);
      acc_q         <= accept_m;
      if (accept_m) begin
        exp_q <= exp_now;
      end
    end
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  pred_valid_a : assert property (@(posedge clk_i) disable iff (rst_i) pred_valid_o == acc_q)
    else abort_run($sformatf("error %s: pred_valid expected %0b actual %0b",
                             test_name, $sampled(acc_q), $sampled(pred_valid_o)));

  pred_taken_a : assert property (@(posedge clk_i) disable iff (rst_i)
    acc_q |-> pred_o.valid == exp_q.valid)
    else abort_run($sformatf("error %s: taken expected %0b actual %0b",
                             test_name, $sampled(exp_q.valid), $sampled(pred_o.valid)));

  pred_slot_a : assert property (@(posedge clk_i) disable iff (rst_i)
    acc_q && exp_q.valid |-> pred_o.slot == exp_q.slot)
    else abort_run($sformatf("error %s: slot expected %0d actual %0d",
                             test_name, $sampled(exp_q.slot), $sampled(pred_o.slot)));

  pred_slot_pc_a : assert property (@(posedge clk_i) disable iff (rst_i)
    acc_q && exp_q.valid |-> pred_o.slot_pc == exp_q.slot_pc)
    else abort_run($sformatf("error %s: slot pc expected %h actual %h",
                             test_name, $sampled(exp_q.slot_pc), $sampled(pred_o.slot_pc)));

  // a taken slot redirects to its target.
  pred_target_a : assert property (@(posedge clk_i) disable iff (rst_i)
    acc_q && exp_q.valid |-> pred_o.target == exp_q.npc)
    else abort_run($sformatf("error %s: target expected %h actual %h",
                             test_name, $sampled(exp_q.npc), $sampled(pred_o.target)));

  pred_kind_a : assert property (@(posedge clk_i) disable iff (rst_i)
    acc_q && exp_q.valid |-> {pred_o.is_call, pred_o.is_ret} == {exp_q.is_call, exp_q.is_ret})
    else abort_run($sformatf("error %s: call/ret expected %b actual %b",
                             test_name, $sampled({exp_q.is_call, exp_q.is_ret}),
                             $sampled({pred_o.is_call, pred_o.is_ret})));

  pred_npc_a : assert property (@(posedge clk_i) disable iff (rst_i)
    acc_q |-> pred_o.npc == exp_q.npc)
    else abort_run($sformatf("error %s: npc expected %h actual %h",
                             test_name, $sampled(exp_q.npc), $sampled(pred_o.npc)));

  ready_a : assert property (@(posedge clk_i) disable iff (rst_i)
    req_ready_o == (model_credits != 0))
    else abort_run($sformatf("error %s: req_ready expected %0b actual %0b",
                             test_name, $sampled(model_credits != 0), $sampled(req_ready_o)));

  // dut credit counter follows the model.
  credit_count_a : assert property (@(posedge clk_i) disable iff (rst_i)
    int'(dut_i.u_next_pc_select.credit_q) == model_credits)
    else abort_run($sformatf("error %s: credit count expected %0d actual %0d",
                             test_name, $sampled(model_credits),
                             $sampled(dut_i.u_next_pc_select.credit_q)));

  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  function automatic logic [`BP_PLEN-1:0] fall_through(input logic [`BP_PLEN-1:0] pc);
    return pc + `BP_PLEN'(4 * `BP_SLOTS);
  endfunction

  function automatic logic committed_as(input logic [`BP_PLEN-1:0] pc,
                                        input bp_commit_pkg::branch_kind_e kind);
    return kind_at.exists(pc) && (kind_at[pc] == kind);
  endfunction

  task automatic fetch(input string name, input logic [`BP_PLEN-1:0] pc, input logic taken,
                       input int slot, input logic [`BP_PLEN-1:0] npc);
    test_name       = name;
    exp_now.valid   = taken;
    exp_now.slot    = bp_fetch_pkg::SLOT_W'(slot);
    exp_now.slot_pc = pc + `BP_PLEN'(4 * slot);
    exp_now.npc     = npc;
    exp_now.is_call = taken && committed_as(exp_now.slot_pc, bp_commit_pkg::BR_CALL);
    exp_now.is_ret  = taken && committed_as(exp_now.slot_pc, bp_commit_pkg::BR_RET);
    req_i.pc        = pc;
    req_valid_i     = 1'b1;
    while (!req_ready_o) begin
      next_cycle();
    end
    next_cycle();                      // accepted here.
    req_valid_i = 1'b0;
    if (auto_credit) begin
      credit_return_i = 1'b1;          // queue frees the entry at once.
    end
    next_cycle();
    if (auto_credit) begin
      credit_return_i = 1'b0;
    end
  endtask

  task automatic commit(input logic [`BP_PLEN-1:0] pc, input bp_commit_pkg::branch_kind_e kind,
                        input logic taken, input logic [`BP_PLEN-1:0] target);
    kind_at[pc]  = kind;
    upd_i.pc     = pc;
    upd_i.kind   = kind;
    upd_i.taken  = taken;
    upd_i.target = target;
    upd_valid_i  = 1'b1;
    next_cycle();
    upd_valid_i  = 1'b0;
  endtask

  task automatic flush();
    flush_i = 1'b1;
    next_cycle();
    flush_i = 1'b0;
  endtask

  task automatic return_credit();
    credit_return_i = 1'b1;
    next_cycle();
    credit_return_i = 1'b0;
  endtask

  initial begin
    logic [31:0] r;
    rst_i           = 1'b1;
    req_valid_i     = 1'b0;
    req_i           = '0;
    credit_return_i = 1'b0;
    upd_valid_i     = 1'b0;
    upd_i           = '0;
    flush_i         = 1'b0;
    auto_credit     = 1'b1;
    exp_now         = '0;
    test_name       = "reset";
    repeat (10) @(posedge clk_i);
    #2;
    rst_i = 1'b0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed: pcs below 0x100 so each lands on its own index
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    fetch("cold", 32'h0000_1000, 1'b0, 0, fall_through(32'h0000_1000));
    fetch("cold", 32'h0000_2340, 1'b0, 0, fall_through(32'h0000_2340));
    fetch("cold", 32'h0000_0010, 1'b0, 0, fall_through(32'h0000_0010));

    commit(32'h0000_0014, bp_commit_pkg::BR_JUMP, 1'b1, 32'h0000_4000);
    fetch("jump slot 1", 32'h0000_0010, 1'b1, 1, 32'h0000_4000);

    commit(32'h0000_0020, bp_commit_pkg::BR_COND, 1'b1, 32'h0000_0200);
    fetch("cond taken once", 32'h0000_0020, 1'b1, 0, 32'h0000_0200);
    commit(32'h0000_0020, bp_commit_pkg::BR_COND, 1'b0, 32'h0000_0200);
    commit(32'h0000_0020, bp_commit_pkg::BR_COND, 1'b0, 32'h0000_0200);
    fetch("cond not taken twice", 32'h0000_0020, 1'b0, 0, fall_through(32'h0000_0020));

    // taken then not taken leaves the counter back at 01.
    commit(32'h0000_0030, bp_commit_pkg::BR_COND, 1'b1, 32'h0000_0008);
    commit(32'h0000_0030, bp_commit_pkg::BR_COND, 1'b0, 32'h0000_0008);
    fetch("cond backward weak", 32'h0000_0030, 1'b1, 0, 32'h0000_0008);

    commit(32'h0000_0040, bp_commit_pkg::BR_JUMP, 1'b1, 32'h0000_0500);
    commit(32'h0000_0044, bp_commit_pkg::BR_JUMP, 1'b1, 32'h0000_0600);
    fetch("first taken slot", 32'h0000_0040, 1'b1, 0, 32'h0000_0500);

    commit(32'h0000_0068, bp_commit_pkg::BR_RET, 1'b1, 32'h0000_0c00);
    commit(32'h0000_0050, bp_commit_pkg::BR_CALL, 1'b1, 32'h0000_0900);
    flush();
    fetch("return after flush", 32'h0000_0068, 1'b1, 0, 32'h0000_0054);
    commit(32'h0000_0074, bp_commit_pkg::BR_CALL, 1'b1, 32'h0000_0a00);
    fetch("predicted call", 32'h0000_0070, 1'b1, 1, 32'h0000_0a00);
    fetch("return after call", 32'h0000_0068, 1'b1, 0, 32'h0000_0078);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // credits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    auto_credit = 1'b0;
    for (int i = 0; i < `BP_CREDITS; i++) begin
      fetch("credit drain", 32'h0000_1000 + 32'(16 * i), 1'b0, 0,
            fall_through(32'h0000_1000 + 32'(16 * i)));
    end
    fork
      fetch("credit stall", 32'h0000_1200, 1'b0, 0, fall_through(32'h0000_1200));
      begin
        repeat (5) next_cycle();       // request held while stalled.
        return_credit();
      end
    join

    test_name   = "random credits";
    exp_now     = '0;
    exp_now.npc = fall_through(32'h0000_3000);
    req_i.pc    = 32'h0000_3000;
    for (int i = 0; i < RAND_CYCLES; i++) begin
      r               = $random(seed);
      req_valid_i     = r[0];
      credit_return_i = r[1] && (model_credits < `BP_CREDITS);
      next_cycle();
    end
    req_valid_i     = 1'b0;
    credit_return_i = 1'b0;
    next_cycle();
    next_cycle();

    $display("SIMULATION PASSED");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, the run is stuck", WATCHDOG_CYCLES);
    $display("SIMULATION FAILED");
    $fatal(1, "timeout");
  end

endmodule : tb_branch_predictor

// File: src/branch_predictor.sv
`timescale 1ns/1ns
`include "bp_cfg.svh"

module branch_predictor (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           req_valid_i,
  input  bp_fetch_pkg::fetch_req_t       req_i,
  output logic                           req_ready_o,
  output logic                           pred_valid_o,
  output bp_fetch_pkg::prediction_t      pred_o,
  input  logic                           credit_return_i,
  input  logic                           upd_valid_i,
  input  bp_commit_pkg::branch_update_t  upd_i,
  input  logic                           flush_i
);

  bp_fetch_pkg::slot_lookup_t [`BP_SLOTS-1:0] slots;
  logic [`BP_PLEN-1:0] spec_top;
  logic                spec_has_entry;
  logic                spec_push;
  logic                spec_pop;
  logic [`BP_PLEN-1:0] spec_ret_addr;

  target_predictor u_target_predictor (
    .clk_i, .rst_i,
    .lookup_pc_i (req_i.pc),
    .upd_valid_i, .upd_i,
    .slots_o     (slots)
  );

  return_stack u_return_stack (
    .clk_i, .rst_i, .upd_valid_i, .upd_i, .flush_i,
    .spec_push_i      (spec_push),
    .spec_pop_i       (spec_pop),
    .spec_ret_addr_i  (spec_ret_addr),
    .spec_top_o       (spec_top),
    .spec_has_entry_o (spec_has_entry)
  );

  next_pc_select u_next_pc_select (
    .clk_i, .rst_i, .req_valid_i, .req_i, .req_ready_o,
    .slots_i          (slots),
    .spec_top_i       (spec_top),
    .spec_has_entry_i (spec_has_entry),
    .flush_i, .credit_return_i, .pred_valid_o, .pred_o,
    .spec_push_o      (spec_push),
    .spec_pop_o       (spec_pop),
    .spec_ret_addr_o  (spec_ret_addr)
  );

endmodule : branch_predictor

// File: src/next_pc_select.sv
`timescale 1ns/1ns
`include "bp_cfg.svh"

module next_pc_select (
  input  logic                                        clk_i,
  input  logic                                        rst_i,
  input  logic                                        req_valid_i,
  input  bp_fetch_pkg::fetch_req_t                    req_i,
  output logic                                        req_ready_o,
  input  bp_fetch_pkg::slot_lookup_t [`BP_SLOTS-1:0]  slots_i,
  input  logic [`BP_PLEN-1:0]                         spec_top_i,
  input  logic                                        spec_has_entry_i,
  input  logic                                        flush_i,
  input  logic                                        credit_return_i,
  output logic                                        pred_valid_o,
  output bp_fetch_pkg::prediction_t                   pred_o,
  output logic                                        spec_push_o,
  output logic                                        spec_pop_o,
  output logic [`BP_PLEN-1:0]                         spec_ret_addr_o
);

  localparam int unsigned CNT_W = $clog2(`BP_CREDITS + 1);

  logic [CNT_W-1:0]          credit_q;
  logic                      accept;
  logic                      pred_valid_q;
  bp_fetch_pkg::prediction_t pred_d, pred_q;

  assign req_ready_o = (credit_q != '0);
  assign accept      = req_valid_i && req_ready_o;

  // lowest taken slot wins.
  always_comb begin
    pred_d         = '0;
    pred_d.slot_pc = req_i.pc;
    pred_d.npc     = req_i.pc + `BP_PLEN'(4 * `BP_SLOTS);
    for (int s = `BP_SLOTS - 1; s >= 0; s--) begin
      if (slots_i[s].taken) begin
        pred_d.valid   = 1'b1;
        pred_d.slot    = bp_fetch_pkg::SLOT_W'(s);
        pred_d.slot_pc = req_i.pc + `BP_PLEN'(4 * s);
        pred_d.is_call = slots_i[s].is_call;
        pred_d.is_ret  = slots_i[s].is_ret;
        pred_d.target  = (slots_i[s].is_ret && spec_has_entry_i) ? spec_top_i
                                                                 : slots_i[s].target;
        pred_d.npc     = pred_d.target;
      end
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      credit_q     <= CNT_W'(`BP_CREDITS);
      pred_valid_q <= 1'b0;
    end else begin
      credit_q     <= credit_q - CNT_W'(accept) + CNT_W'(credit_return_i);
      pred_valid_q <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      pred_q <= pred_d;
    end
  end

  assign pred_valid_o    = pred_valid_q;
  assign pred_o          = pred_q;
  assign spec_push_o     = pred_valid_q && pred_q.valid && pred_q.is_call && !flush_i;
  assign spec_pop_o      = pred_valid_q && pred_q.valid && pred_q.is_ret && !flush_i;
  assign spec_ret_addr_o = pred_q.slot_pc + `BP_PLEN'(4);

  credit_bound_a : assert property (@(posedge clk_i) disable iff (rst_i)
    credit_q <= CNT_W'(`BP_CREDITS))
    else $error("credit count above fetch queue size");

endmodule : next_pc_select

// File: src/return_stack.sv
`timescale 1ns/1ns
`include "bp_cfg.svh"

module return_stack (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           upd_valid_i,
  input  bp_commit_pkg::branch_update_t  upd_i,
  input  logic                           flush_i,
  input  logic                           spec_push_i,
  input  logic                           spec_pop_i,
  input  logic [`BP_PLEN-1:0]            spec_ret_addr_i,
  output logic [`BP_PLEN-1:0]            spec_top_o,
  output logic                           spec_has_entry_o
);

  localparam int unsigned DEPTH = `BP_RAS_DEPTH;
  localparam int unsigned IDX_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  typedef struct packed {
    logic [DEPTH-1:0][`BP_PLEN-1:0] ent;
    logic [CNT_W-1:0]               cnt;
  } ras_t;

  logic [DEPTH-1:0][`BP_PLEN-1:0] arch_ent_q, spec_ent_q;
  logic [CNT_W-1:0]               arch_cnt_q, spec_cnt_q;
  ras_t                           arch_nxt, spec_nxt;

  // full stack drops the oldest entry at index 0.
  function automatic ras_t ras_push(input ras_t s, input logic [`BP_PLEN-1:0] addr);
    ras_t r;
    r = s;
    if (s.cnt < CNT_W'(DEPTH)) begin
      r.ent[s.cnt[IDX_W-1:0]] = addr;
      r.cnt = s.cnt + 1'b1;
    end else begin
      for (int j = 0; j < DEPTH - 1; j++) begin
        r.ent[j] = s.ent[j+1];
      end
      r.ent[DEPTH-1] = addr;
    end
    return r;
  endfunction

  function automatic ras_t ras_pop(input ras_t s);
    ras_t r;
    r = s;
    if (s.cnt != '0) begin
      r.cnt = s.cnt - 1'b1;
    end
    return r;
  endfunction

  always_comb begin
    arch_nxt = '{ent: arch_ent_q, cnt: arch_cnt_q};
    if (upd_valid_i && (upd_i.kind == bp_commit_pkg::BR_CALL)) begin
      arch_nxt = ras_push(arch_nxt, upd_i.pc + `BP_PLEN'(4));
    end else if (upd_valid_i && (upd_i.kind == bp_commit_pkg::BR_RET)) begin
      arch_nxt = ras_pop(arch_nxt);
    end
  end

  always_comb begin
    spec_nxt = '{ent: spec_ent_q, cnt: spec_cnt_q};
    if (flush_i) begin
      spec_nxt = arch_nxt;                 // includes this cycle's commit.
    end else if (spec_push_i) begin
      spec_nxt = ras_push(spec_nxt, spec_ret_addr_i);
    end else if (spec_pop_i) begin
      spec_nxt = ras_pop(spec_nxt);
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      arch_cnt_q <= '0;
      spec_cnt_q <= '0;
    end else begin
      arch_cnt_q <= arch_nxt.cnt;
      spec_cnt_q <= spec_nxt.cnt;
    end
  end

  always_ff @(posedge clk_i) begin
    arch_ent_q <= arch_nxt.ent;
    spec_ent_q <= spec_nxt.ent;
  end

  assign spec_has_entry_o = (spec_cnt_q != '0);
  assign spec_top_o = spec_has_entry_o ? spec_ent_q[IDX_W'(spec_cnt_q - 1'b1)] : '0;

  // a slot is either a call or a return, never both.
  push_pop_excl_a : assert property (@(posedge clk_i) disable iff (rst_i)
    !(spec_push_i && spec_pop_i))
    else $error("ras push and pop in the same cycle");

endmodule : return_stack

// File: src/target_predictor.sv
`timescale 1ns/1ns
`include "bp_cfg.svh"

module target_predictor (
  input  logic                                         clk_i,
  input  logic                                         rst_i,
  input  logic [`BP_PLEN-1:0]                          lookup_pc_i,
  input  logic                                         upd_valid_i,
  input  bp_commit_pkg::branch_update_t                upd_i,
  output bp_fetch_pkg::slot_lookup_t [`BP_SLOTS-1:0]   slots_o
);

  localparam int unsigned PLEN      = `BP_PLEN;
  localparam int unsigned BTB_IDX_W = $clog2(`BP_BTB_ENTRIES);
  localparam int unsigned BHT_IDX_W = $clog2(`BP_BHT_ENTRIES);
  localparam int unsigned TAG_W     = PLEN - 2 - BTB_IDX_W;

  logic [`BP_BTB_ENTRIES-1:0]   btb_valid_q;
  logic [TAG_W-1:0]             btb_tag_q    [`BP_BTB_ENTRIES];
  bp_commit_pkg::branch_kind_e  btb_kind_q   [`BP_BTB_ENTRIES];
  logic [PLEN-1:0]              btb_target_q [`BP_BTB_ENTRIES];
  logic [1:0]                   bht_q        [`BP_BHT_ENTRIES];

  logic [BTB_IDX_W-1:0] upd_btb_idx;
  logic [BHT_IDX_W-1:0] upd_bht_idx;
  logic                 upd_is_cond;
  logic                 upd_write;

  // low index bits start above the byte offset; upper bits xor-folded in.
  function automatic logic [PLEN-1:0] fold_index(input logic [PLEN-1:0] pc,
                                                 input int unsigned     w,
                                                 input logic            hash);
    logic [PLEN-1:0] idx;
    idx = '0;
    for (int i = 2; i < PLEN; i++) begin
      if (i < 2 + w) begin
        idx[i-2] = pc[i];
      end else if (hash) begin
        idx[(i - 2 - w) % w] ^= pc[i];
      end
    end
    return idx;
  endfunction

  function automatic logic [TAG_W-1:0] btb_tag(input logic [PLEN-1:0] pc);
    return pc[PLEN-1 -: TAG_W];
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // lookup
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    logic [PLEN-1:0]      slot_pc;
    logic [BTB_IDX_W-1:0] bi;
    logic [BHT_IDX_W-1:0] hi;
    logic [1:0]           ctr;
    for (int s = 0; s < `BP_SLOTS; s++) begin
      slot_pc = lookup_pc_i + PLEN'(4 * s);
      bi      = BTB_IDX_W'(fold_index(slot_pc, BTB_IDX_W, 1'(`BP_BTB_HASH)));
      hi      = BHT_IDX_W'(fold_index(slot_pc, BHT_IDX_W, 1'(`BP_BHT_HASH)));
      ctr     = bht_q[hi];

      slots_o[s].hit     = btb_valid_q[bi] && (btb_tag_q[bi] == btb_tag(slot_pc));
      slots_o[s].target  = btb_target_q[bi];
      slots_o[s].is_call = slots_o[s].hit && (btb_kind_q[bi] == bp_commit_pkg::BR_CALL);
      slots_o[s].is_ret  = slots_o[s].hit && (btb_kind_q[bi] == bp_commit_pkg::BR_RET);
      slots_o[s].taken   = 1'b0;
      if (slots_o[s].hit) begin
        if (btb_kind_q[bi] != bp_commit_pkg::BR_COND) begin
          slots_o[s].taken = 1'b1;           // unconditional transfer.
        end else begin
          // weakly not-taken still goes for backward loops.
          slots_o[s].taken = ctr[1] || ((ctr == 2'b01) && (btb_target_q[bi] < slot_pc));
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // commit training
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign upd_btb_idx = BTB_IDX_W'(fold_index(upd_i.pc, BTB_IDX_W, 1'(`BP_BTB_HASH)));
  assign upd_bht_idx = BHT_IDX_W'(fold_index(upd_i.pc, BHT_IDX_W, 1'(`BP_BHT_HASH)));
  assign upd_is_cond = (upd_i.kind == bp_commit_pkg::BR_COND);
  assign upd_write   = upd_valid_i && (!upd_is_cond || upd_i.taken);

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      btb_valid_q <= '0;
    end else if (upd_write) begin
      btb_valid_q[upd_btb_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (upd_write) begin
      btb_tag_q[upd_btb_idx]    <= btb_tag(upd_i.pc);
      btb_kind_q[upd_btb_idx]   <= upd_i.kind;
      btb_target_q[upd_btb_idx] <= upd_i.target;
    end
  end

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int i = 0; i < `BP_BHT_ENTRIES; i++) begin
        bht_q[i] <= 2'b01;                   // weakly not taken.
      end
    end else if (upd_valid_i) begin
      if (!upd_is_cond) begin
        bht_q[upd_bht_idx] <= 2'b11;
      end else if (upd_i.taken && (bht_q[upd_bht_idx] != 2'b11)) begin
        bht_q[upd_bht_idx] <= bht_q[upd_bht_idx] + 2'b01;
      end else if (!upd_i.taken && (bht_q[upd_bht_idx] != 2'b00)) begin
        bht_q[upd_bht_idx] <= bht_q[upd_bht_idx] - 2'b01;
      end
    end
  end

endmodule : target_predictor

// File: src/bp_commit_pkg.sv
`include "bp_cfg.svh"

package bp_commit_pkg;

  typedef enum logic [1:0] {
    BR_COND = 2'd0,
    BR_JUMP = 2'd1,
    BR_CALL = 2'd2,
    BR_RET  = 2'd3
  } branch_kind_e;

  // one retired control transfer.
  typedef struct packed {
    logic [`BP_PLEN-1:0] pc;
    branch_kind_e        kind;
    logic                taken;    // only meaningful for cond.
    logic [`BP_PLEN-1:0] target;
  } branch_update_t;

endpackage : bp_commit_pkg

// File: src/bp_fetch_pkg.sv
`include "bp_cfg.svh"

package bp_fetch_pkg;

  localparam int unsigned SLOT_W = (`BP_SLOTS > 1) ? $clog2(`BP_SLOTS) : 1;

  typedef struct packed {
    logic [`BP_PLEN-1:0] pc;  // fetch block address.
  } fetch_req_t;

  // per-slot view of the target buffer.
  typedef struct packed {
    logic                hit;
    logic                taken;
    logic                is_call;
    logic                is_ret;
    logic [`BP_PLEN-1:0] target;   // stored target, not yet ras substituted.
  } slot_lookup_t;

  typedef struct packed {
    logic                valid;    // some slot predicted taken.
    logic [SLOT_W-1:0]   slot;
    logic [`BP_PLEN-1:0] slot_pc;
    logic [`BP_PLEN-1:0] target;
    logic [`BP_PLEN-1:0] npc;
    logic                is_call;
    logic                is_ret;
  } prediction_t;

endpackage : bp_fetch_pkg

// File: include/bp_cfg.svh
`ifndef BP_CFG_SVH
`define BP_CFG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch block geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define BP_PLEN         32   // address width.
`define BP_SLOTS        2    // 4-byte slots per fetch block.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// predictor tables
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define BP_BTB_ENTRIES  64   // direct mapped.
`define BP_BHT_ENTRIES  128  // 2-bit counters.
`define BP_RAS_DEPTH    8
`define BP_CREDITS      4    // fetch queue entries.

// fold the upper pc bits into the index when set.
`define BP_BTB_HASH     1
`define BP_BHT_HASH     1

`endif
